// ==== exu_pkg.sv ====
package exu_pkg;

	// widths fixed by RV32 and the 64-bit data bus
	localparam int XLEN = 32;
	localparam int BUS_WIDTH = 64;
	localparam int STRB_WIDTH = 8;
	localparam int REG_ADDR_WIDTH = 5;
	localparam int SIZE_WIDTH = 3;
	localparam int BEAT_OFFSET_WIDTH = 3;

	// address constants
	localparam logic [XLEN-1:0] LINK_OFFSET = 32'd4;
	localparam logic [XLEN-1:0] BEAT_BYTES = 32'd8;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
		ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_EQ
	} alu_op_e;

	typedef enum logic [3:0] {
		MEM_NONE, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_SB, MEM_SH, MEM_SW
	} mem_op_e;

	typedef enum logic [2:0] {
		CTRL_PLAIN, CTRL_BRANCH_EQ, CTRL_BRANCH_NE, CTRL_BRANCH_LT,
		CTRL_BRANCH_GE, CTRL_JAL, CTRL_JALR
	} ctrl_kind_e;

	typedef struct packed {
		alu_op_e alu_op;
		mem_op_e mem_op;
		ctrl_kind_e kind;
		logic [XLEN-1:0] src1;
		logic [XLEN-1:0] src2;
		logic [XLEN-1:0] store_data;
		logic [XLEN-1:0] branch_target;
		logic [XLEN-1:0] pc;
		logic [REG_ADDR_WIDTH-1:0] rd;
		logic wen;
	} exu_req_t;

	typedef struct packed {
		logic wen;
		logic [REG_ADDR_WIDTH-1:0] rd;
		logic [XLEN-1:0] data;
	} exu_wb_t;

	typedef struct packed {
		logic taken;
		logic [XLEN-1:0] target;
	} exu_redirect_t;

	typedef struct packed {
		logic [XLEN-1:0] addr;
		logic [SIZE_WIDTH-1:0] size;
	} mem_addr_t;

	typedef struct packed {
		logic [BUS_WIDTH-1:0] data;
		logic [STRB_WIDTH-1:0] strb;
	} mem_wdata_t;

	function automatic logic is_load_op(mem_op_e op);
		is_load_op = (op == MEM_LB) || (op == MEM_LBU) || (op == MEM_LH) ||
			(op == MEM_LHU) || (op == MEM_LW);
	endfunction

	function automatic logic is_store_op(mem_op_e op);
		is_store_op = (op == MEM_SB) || (op == MEM_SH) || (op == MEM_SW);
	endfunction

	// bus size code follows the access width
	function automatic logic [SIZE_WIDTH-1:0] access_size(mem_op_e op);
		case (op)
			MEM_LB, MEM_LBU, MEM_SB: access_size = 3'd0;
			MEM_LH, MEM_LHU, MEM_SH: access_size = 3'd1;
			default: access_size = 3'd2;
		endcase
	endfunction

endpackage

// ==== exu_alu.sv ====
`timescale 1ns/10ps
module exu_alu (
	input exu_pkg::alu_op_e op,
	input logic [exu_pkg::XLEN-1:0] a,
	input logic [exu_pkg::XLEN-1:0] b,
	output logic [exu_pkg::XLEN-1:0] result
);
	import exu_pkg::*;

	logic [$clog2(XLEN)-1:0] shamt;

	assign shamt = b[$clog2(XLEN)-1:0];

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SLL: result = a << shamt;
			ALU_SRL: result = a >> shamt;
			ALU_SRA: result = $signed(a) >>> shamt;
			// compares give 0 or 1, bit 0 feeds the branch decision
			ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
			ALU_EQ: result = {{(XLEN-1){1'b0}}, a == b};
			default: result = '0;
		endcase
	end

endmodule

// ==== exu_control.sv ====
`timescale 1ns/10ps
module exu_control (
	input logic clock,
	input logic reset,
	input logic in_valid,
	input exu_pkg::exu_req_t in_req,
	input logic [exu_pkg::XLEN-1:0] alu_result,
	input logic [exu_pkg::XLEN-1:0] load_data,
	input logic mem_done,
	output logic allowin,
	output exu_pkg::exu_req_t req,
	output logic mem_start,
	output logic out_valid,
	output exu_pkg::exu_wb_t wb,
	output exu_pkg::exu_redirect_t redirect
);
	import exu_pkg::*;

	logic valid;
	logic is_mem;
	logic ready_go;
	logic cond;
	logic is_jump;

	assign is_mem = is_load_op(req.mem_op) || is_store_op(req.mem_op);
	assign mem_start = valid && is_mem && !mem_done;
	// memory ops wait for the unit, everything else finishes at once
	assign ready_go = is_mem ? mem_done : 1'b1;
	assign allowin = !valid || ready_go;
	assign out_valid = valid && ready_go;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= 1'b0;
		end else if (allowin) begin
			valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid && allowin) begin
			req <= in_req;
		end
	end

	assign cond = alu_result[0];
	assign is_jump = (req.kind == CTRL_JAL) || (req.kind == CTRL_JALR);

	// ne and ge reuse the eq and slt compares, inverted
	always_comb begin
		redirect.target = req.branch_target;
		case (req.kind)
			CTRL_BRANCH_EQ, CTRL_BRANCH_LT: redirect.taken = cond;
			CTRL_BRANCH_NE, CTRL_BRANCH_GE: redirect.taken = !cond;
			CTRL_JAL: redirect.taken = 1'b1;
			CTRL_JALR: begin
				redirect.taken = 1'b1;
				redirect.target = {alu_result[XLEN-1:1], 1'b0};
			end
			default: redirect.taken = 1'b0;
		endcase
	end

	always_comb begin
		wb.wen = req.wen;
		wb.rd = req.rd;
		if (is_jump) begin
			wb.data = req.pc + LINK_OFFSET;
		end else if (is_load_op(req.mem_op)) begin
			wb.data = load_data;
		end else begin
			wb.data = alu_result;
		end
	end

	// a stalled instruction must not be overwritten by the decoder
	req_hold: assert property (@(posedge clock) disable iff (reset)
		valid && !allowin |=> $stable(req));

endmodule

// ==== exu_load_unit.sv ====
`timescale 1ns/10ps
module exu_load_unit (
	input logic clock,
	input logic reset,
	input logic start,
	input exu_pkg::mem_op_e mem_op,
	input logic [exu_pkg::XLEN-1:0] addr,
	input logic ar_ready,
	input logic r_valid,
	input logic [exu_pkg::BUS_WIDTH-1:0] r_data,
	output logic ar_valid,
	output exu_pkg::mem_addr_t ar,
	output logic r_ready,
	output logic done,
	output logic [exu_pkg::XLEN-1:0] load_data
);
	import exu_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE, ST_ADDR, ST_DATA, ST_ADDR2, ST_DATA2, ST_FINISH
	} state_e;

	state_e state;
	state_e next_state;
	logic [BEAT_OFFSET_WIDTH-1:0] offset;
	logic [XLEN-1:0] aligned_addr;
	logic need_second;
	logic [BUS_WIDTH-1:0] first_beat;
	logic [BUS_WIDTH-1:0] second_beat;
	logic [2*BUS_WIDTH-1:0] beats;
	logic [XLEN-1:0] raw;

	assign offset = addr[BEAT_OFFSET_WIDTH-1:0];
	assign aligned_addr = {addr[XLEN-1:BEAT_OFFSET_WIDTH], {BEAT_OFFSET_WIDTH{1'b0}}};
	// word at 5..7 or half at 7 spills into the next beat
	assign need_second = ((mem_op == MEM_LW) && (offset >= 3'd5)) ||
		(((mem_op == MEM_LH) || (mem_op == MEM_LHU)) && (offset == 3'd7));

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE: if (start) next_state = ST_ADDR;
			ST_ADDR: if (ar_valid && ar_ready) next_state = ST_DATA;
			ST_DATA: if (r_valid) next_state = need_second ? ST_ADDR2 : ST_FINISH;
			ST_ADDR2: if (ar_valid && ar_ready) next_state = ST_DATA2;
			ST_DATA2: if (r_valid) next_state = ST_FINISH;
			default: next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// registered valid, the second request goes out a cycle after entering addr2
	always_ff @(posedge clock) begin
		if (reset) begin
			ar_valid <= 1'b0;
		end else if (ar_valid && ar_ready) begin
			ar_valid <= 1'b0;
		end else if ((state == ST_IDLE && start) || state == ST_ADDR2) begin
			ar_valid <= 1'b1;
		end
	end

	assign ar.addr = (state == ST_ADDR2) ? aligned_addr + BEAT_BYTES : aligned_addr;
	assign ar.size = access_size(mem_op);
	assign r_ready = (state == ST_DATA) || (state == ST_DATA2);
	assign done = (state == ST_FINISH);

	always_ff @(posedge clock) begin
		if (state == ST_DATA && r_valid) begin
			first_beat <= r_data;
		end
		if (state == ST_DATA2 && r_valid) begin
			second_beat <= r_data;
		end
	end

	// bytes from the offset onward, across both beats
	assign beats = {second_beat, first_beat};
	assign raw = beats[{offset, 3'b000} +: XLEN];

	always_comb begin
		case (mem_op)
			MEM_LB: load_data = {{(XLEN-8){raw[7]}}, raw[7:0]};
			MEM_LBU: load_data = {{(XLEN-8){1'b0}}, raw[7:0]};
			MEM_LH: load_data = {{(XLEN-16){raw[15]}}, raw[15:0]};
			MEM_LHU: load_data = {{(XLEN-16){1'b0}}, raw[15:0]};
			default: load_data = raw;
		endcase
	end

	ar_stable: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar));

endmodule

// ==== exu_store_unit.sv ====
`timescale 1ns/10ps
module exu_store_unit (
	input logic clock,
	input logic reset,
	input logic start,
	input exu_pkg::mem_op_e mem_op,
	input logic [exu_pkg::XLEN-1:0] addr,
	input logic [exu_pkg::XLEN-1:0] store_data,
	input logic aw_ready,
	input logic w_ready,
	input logic b_valid,
	output logic aw_valid,
	output exu_pkg::mem_addr_t aw,
	output logic w_valid,
	output exu_pkg::mem_wdata_t w,
	output logic w_last,
	output logic b_ready,
	output logic done
);
	import exu_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE, ST_ADDR, ST_DATA, ST_RESP, ST_FINISH
	} state_e;

	state_e state;
	logic [STRB_WIDTH-1:0] strb_mask;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (start) state <= ST_ADDR;
				ST_ADDR: if (aw_ready) state <= ST_DATA;
				ST_DATA: if (w_ready) state <= ST_RESP;
				ST_RESP: if (b_valid) state <= ST_FINISH;
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign aw_valid = (state == ST_ADDR);
	assign w_valid = (state == ST_DATA);
	// single-beat bursts, so every data beat is the last
	assign w_last = (state == ST_DATA);
	assign b_ready = (state == ST_RESP);
	assign done = (state == ST_FINISH);

	assign aw.addr = addr;
	assign aw.size = access_size(mem_op);

	always_comb begin
		case (mem_op)
			MEM_SB: strb_mask = 8'h01;
			MEM_SH: strb_mask = 8'h03;
			default: strb_mask = 8'h0f;
		endcase
	end

	// bytes past the end of the beat fall off the shift
	assign w.strb = strb_mask << addr[BEAT_OFFSET_WIDTH-1:0];
	assign w.data = {store_data, store_data};

	w_after_aw: assert property (@(posedge clock) disable iff (reset)
		$rose(w_valid) |-> $past(aw_valid && aw_ready));

endmodule

// ==== exu_top.sv ====
`timescale 1ns/10ps
module exu_top (
	input logic clock,
	input logic reset,
	input logic in_valid,
	input exu_pkg::exu_req_t in_req,
	input logic ar_ready,
	input logic r_valid,
	input logic [exu_pkg::BUS_WIDTH-1:0] r_data,
	input logic aw_ready,
	input logic w_ready,
	input logic b_valid,
	output logic allowin,
	output logic out_valid,
	output exu_pkg::exu_wb_t wb,
	output exu_pkg::exu_redirect_t redirect,
	output logic ar_valid,
	output exu_pkg::mem_addr_t ar,
	output logic r_ready,
	output logic aw_valid,
	output exu_pkg::mem_addr_t aw,
	output logic w_valid,
	output exu_pkg::mem_wdata_t w,
	output logic w_last,
	output logic b_ready
);
	import exu_pkg::*;

	exu_req_t req;
	logic [XLEN-1:0] alu_result;
	logic [XLEN-1:0] load_data;
	logic mem_start;
	logic mem_done;
	logic load_start;
	logic store_start;
	logic load_done;
	logic store_done;

	// each unit only sees start for its own class of op
	assign load_start = mem_start && is_load_op(req.mem_op);
	assign store_start = mem_start && is_store_op(req.mem_op);
	assign mem_done = load_done || store_done;

	exu_control i_exu_control (
		.clock(clock), .reset(reset), .in_valid(in_valid), .in_req(in_req),
		.alu_result(alu_result), .load_data(load_data), .mem_done(mem_done),
		.allowin(allowin), .req(req), .mem_start(mem_start), .out_valid(out_valid),
		.wb(wb), .redirect(redirect)
	);

	exu_alu i_exu_alu (
		.op(req.alu_op), .a(req.src1), .b(req.src2), .result(alu_result)
	);

	exu_load_unit i_exu_load_unit (
		.clock(clock), .reset(reset), .start(load_start), .mem_op(req.mem_op),
		.addr(alu_result), .ar_ready(ar_ready), .r_valid(r_valid), .r_data(r_data),
		.ar_valid(ar_valid), .ar(ar), .r_ready(r_ready), .done(load_done),
		.load_data(load_data)
	);

	exu_store_unit i_exu_store_unit (
		.clock(clock), .reset(reset), .start(store_start), .mem_op(req.mem_op),
		.addr(alu_result), .store_data(req.store_data), .aw_ready(aw_ready),
		.w_ready(w_ready), .b_valid(b_valid), .aw_valid(aw_valid), .aw(aw),
		.w_valid(w_valid), .w(w), .w_last(w_last), .b_ready(b_ready), .done(store_done)
	);

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/10ps
module tb_mem_model (
	input logic clock,
	input logic reset,
	input logic ar_valid,
	input exu_pkg::mem_addr_t ar,
	output logic ar_ready,
	output logic r_valid,
	output logic [exu_pkg::BUS_WIDTH-1:0] r_data,
	input logic r_ready,
	input logic aw_valid,
	input exu_pkg::mem_addr_t aw,
	output logic aw_ready,
	input logic w_valid,
	input exu_pkg::mem_wdata_t w,
	input logic w_last,
	output logic w_ready,
	output logic b_valid,
	input logic b_ready
);
	import exu_pkg::*;

	logic [7:0] mem [0:255];
	logic [7:0] rd_base;
	logic [7:0] wr_base;
	logic rd_pend;
	logic b_pend;
	integer seed;
	int protocol_errors;

	initial begin
		seed = 32'h8df01236;
		protocol_errors = 0;
		for (int i = 0; i < 256; i++) mem[i] = 8'(i);
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r_data = '0;
		aw_ready = 1'b0;
		w_ready = 1'b0;
		b_valid = 1'b0;
		rd_pend = 1'b0;
		b_pend = 1'b0;
		rd_base = '0;
		wr_base = '0;
	end

	// sample handshakes at the edge, drive new values 1 ns later
	always @(posedge clock) begin : step
		logic r_fire;
		logic b_fire;
		r_fire = r_valid && r_ready;
		b_fire = b_valid && b_ready;
		if (reset) begin
			rd_pend = 1'b0;
			b_pend = 1'b0;
		end else begin
			if (ar_valid && ar_ready) begin
				rd_base = {ar.addr[7:3], 3'b000};
				rd_pend = 1'b1;
			end
			if (r_fire) rd_pend = 1'b0;
			if (aw_valid && aw_ready) wr_base = {aw.addr[7:3], 3'b000};
			if (w_valid && w_ready) begin
				for (int k = 0; k < 8; k++) begin
					if (w.strb[k]) mem[8'(wr_base + 8'(k))] = w.data[8*k +: 8];
				end
				b_pend = 1'b1;
			end
			if (b_fire) b_pend = 1'b0;
		end
		#1;
		ar_ready = !reset && (($random(seed) & 3) != 0);
		aw_ready = !reset && (($random(seed) & 3) != 0);
		w_ready = !reset && (($random(seed) & 3) != 0);
		// a raised valid holds until its transfer
		if (!r_valid || r_fire) begin
			r_valid = rd_pend && (($random(seed) & 1) != 0);
			for (int k = 0; k < 8; k++) r_data[8*k +: 8] = mem[8'(rd_base + 8'(k))];
		end
		if (!b_valid || b_fire) b_valid = b_pend && (($random(seed) & 1) != 0);
	end

	ar_hold: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else begin
			protocol_errors++;
			$display("read address valid or payload changed before its transfer at %0t", $time);
		end

	aw_hold: assert property (@(posedge clock) disable iff (reset)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw))
		else begin
			protocol_errors++;
			$display("write address valid or payload changed before its transfer at %0t", $time);
		end

	w_hold: assert property (@(posedge clock) disable iff (reset)
		w_valid && !w_ready |=> w_valid && $stable(w) && w_last)
		else begin
			protocol_errors++;
			$display("write data valid, payload or last changed before its transfer at %0t", $time);
		end

endmodule

// ==== tb_exu.sv ====
`timescale 1ns/10ps
module tb_exu;
	import exu_pkg::*;

	localparam int N_INSTR = 145;
	localparam int TIMEOUT_NS = (N_INSTR * 40 + 20) * 10;

	logic clock = 1'b0;
	logic reset;
	logic in_valid;
	exu_req_t in_req;
	logic allowin, out_valid;
	exu_wb_t wb;
	exu_redirect_t redirect;
	logic ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready;
	logic w_valid, w_ready, w_last, b_valid, b_ready;
	logic [BUS_WIDTH-1:0] r_data;
	mem_addr_t ar, aw;
	mem_wdata_t w;

	integer seed = 32'h8df01236;
	int errors = 0;
	int ar_count = 0;
	logic [7:0] ref_mem [0:255];
	// expectations for the instruction in flight
	logic [31:0] exp_data, exp_target, exp_addr, exp_wdata;
	logic [4:0] exp_rd;
	logic [7:0] exp_strb;
	logic [2:0] exp_size;
	logic chk_data, exp_taken, exp_mem, exp_load, exp_wen;
	int exp_beats;

	always #5 clock = ~clock;

	exu_top i_exu_top (
		.clock(clock), .reset(reset), .in_valid(in_valid), .in_req(in_req),
		.ar_ready(ar_ready), .r_valid(r_valid), .r_data(r_data), .aw_ready(aw_ready),
		.w_ready(w_ready), .b_valid(b_valid), .allowin(allowin), .out_valid(out_valid),
		.wb(wb), .redirect(redirect), .ar_valid(ar_valid), .ar(ar), .r_ready(r_ready),
		.aw_valid(aw_valid), .aw(aw), .w_valid(w_valid), .w(w), .w_last(w_last),
		.b_ready(b_ready)
	);

	tb_mem_model i_mem_model (
		.clock(clock), .reset(reset), .ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready),
		.r_valid(r_valid), .r_data(r_data), .r_ready(r_ready), .aw_valid(aw_valid),
		.aw(aw), .aw_ready(aw_ready), .w_valid(w_valid), .w(w), .w_last(w_last),
		.w_ready(w_ready), .b_valid(b_valid), .b_ready(b_ready)
	);

	// read requests of the current instruction
	always @(posedge clock) begin
		if (in_valid && allowin) ar_count <= 0;
		else if (ar_valid && ar_ready) ar_count <= ar_count + 1;
	end

	a_wb_data: assert property (@(posedge clock) disable iff (reset)
		out_valid && chk_data |-> wb.data == exp_data)
		else begin
			errors++;
			$display("ERROR %0t wb.data expected %h got %h", $time, exp_data, $sampled(wb.data));
		end
	a_wb_rd: assert property (@(posedge clock) disable iff (reset) out_valid |-> wb.rd == exp_rd)
		else begin
			errors++;
			$display("ERROR %0t wb.rd expected %0d got %0d", $time, exp_rd, $sampled(wb.rd));
		end
	a_wb_wen: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> wb.wen == exp_wen)
		else begin
			errors++;
			$display("ERROR %0t wb.wen expected %b got %b", $time, exp_wen, $sampled(wb.wen));
		end
	a_taken: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> redirect.taken == exp_taken)
		else begin
			errors++;
			$display("ERROR %0t redirect.taken expected %b got %b", $time, exp_taken,
				$sampled(redirect.taken));
		end
	a_target: assert property (@(posedge clock) disable iff (reset)
		out_valid && exp_taken |-> redirect.target == exp_target)
		else begin
			errors++;
			$display("ERROR %0t redirect.target expected %h got %h", $time, exp_target,
				$sampled(redirect.target));
		end
	a_latency: assert property (@(posedge clock) disable iff (reset)
		in_valid && allowin && !exp_mem |=> out_valid)
		else begin
			errors++;
			$display("ERROR %0t out_valid expected 1 got 0", $time);
		end
	a_beats: assert property (@(posedge clock) disable iff (reset)
		out_valid && exp_load |-> ar_count == exp_beats)
		else begin
			errors++;
			$display("ERROR %0t ar transfers expected %0d got %0d", $time, exp_beats,
				$sampled(ar_count));
		end
	a_ar_addr: assert property (@(posedge clock) disable iff (reset)
		ar_valid && ar_ready |-> ar.addr == {exp_addr[31:3], 3'b000} + (ar_count != 0 ? 8 : 0))
		else begin
			errors++;
			$display("ERROR %0t ar.addr expected %h got %h", $time,
				{exp_addr[31:3], 3'b000} + ($sampled(ar_count) != 0 ? 32'd8 : 32'd0),
				$sampled(ar.addr));
		end
	a_ar_size: assert property (@(posedge clock) disable iff (reset)
		ar_valid |-> ar.size == exp_size)
		else begin
			errors++;
			$display("ERROR %0t ar.size expected %0d got %0d", $time, exp_size, $sampled(ar.size));
		end
	a_aw_addr: assert property (@(posedge clock) disable iff (reset)
		aw_valid |-> aw.addr == exp_addr)
		else begin
			errors++;
			$display("ERROR %0t aw.addr expected %h got %h", $time, exp_addr, $sampled(aw.addr));
		end
	a_aw_size: assert property (@(posedge clock) disable iff (reset)
		aw_valid |-> aw.size == exp_size)
		else begin
			errors++;
			$display("ERROR %0t aw.size expected %0d got %0d", $time, exp_size, $sampled(aw.size));
		end
	a_w_strb: assert property (@(posedge clock) disable iff (reset) w_valid |-> w.strb == exp_strb)
		else begin
			errors++;
			$display("ERROR %0t w.strb expected %h got %h", $time, exp_strb, $sampled(w.strb));
		end
	a_w_data: assert property (@(posedge clock) disable iff (reset)
		w_valid |-> w.data == {exp_wdata, exp_wdata})
		else begin
			errors++;
			$display("ERROR %0t w.data expected %h got %h", $time, {exp_wdata, exp_wdata},
				$sampled(w.data));
		end
	// one beat per store, so every data beat is the last
	a_w_last: assert property (@(posedge clock) disable iff (reset) w_valid |-> w_last)
		else begin
			errors++;
			$display("ERROR %0t w_last expected 1 got 0", $time);
		end
	// stage stays closed while a unit is busy on the bus
	a_busy: assert property (@(posedge clock) disable iff (reset)
		ar_valid || r_ready || aw_valid || w_valid || b_ready |-> !allowin)
		else begin
			errors++;
			$display("ERROR %0t allowin expected 0 got 1", $time);
		end
	a_reset: assert property (@(posedge clock) $fell(reset) |-> !out_valid && !ar_valid &&
		!r_ready && !aw_valid && !w_valid && !w_last && !b_ready)
		else begin
			errors++;
			$display("a control output was not low after reset at %0t", $time);
		end

	function automatic logic [31:0] alu_expect(alu_op_e op, logic [31:0] a, logic [31:0] b);
		case (op)
			ALU_ADD: alu_expect = a + b;
			ALU_SUB: alu_expect = a - b;
			ALU_AND: alu_expect = a & b;
			ALU_OR: alu_expect = a | b;
			ALU_XOR: alu_expect = a ^ b;
			ALU_SLL: alu_expect = a << b[4:0];
			ALU_SRL: alu_expect = a >> b[4:0];
			ALU_SRA: alu_expect = $unsigned($signed(a) >>> b[4:0]);
			ALU_SLT: alu_expect = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLTU: alu_expect = (a < b) ? 32'd1 : 32'd0;
			default: alu_expect = (a == b) ? 32'd1 : 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] load_expect(mem_op_e op, logic [7:0] a);
		logic [31:0] raw;
		for (int k = 0; k < 4; k++) raw[8*k +: 8] = ref_mem[8'(a + 8'(k))];
		case (op)
			MEM_LB: load_expect = {{24{raw[7]}}, raw[7:0]};
			MEM_LBU: load_expect = {24'd0, raw[7:0]};
			MEM_LH: load_expect = {{16{raw[15]}}, raw[15:0]};
			MEM_LHU: load_expect = {16'd0, raw[15:0]};
			default: load_expect = raw;
		endcase
	endfunction

	function automatic exu_req_t make_req(alu_op_e op, mem_op_e mop, ctrl_kind_e kind,
		logic [31:0] s1, logic [31:0] s2, logic [31:0] sd, logic [31:0] tgt, logic [31:0] pc);
		exu_req_t r;
		r.alu_op = op;
		r.mem_op = mop;
		r.kind = kind;
		r.src1 = s1;
		r.src2 = s2;
		r.store_data = sd;
		r.branch_target = tgt;
		r.pc = pc;
		r.rd = '0;
		r.wen = 1'b1;
		return r;
	endfunction

	task automatic clear_expect();
		chk_data = 1'b0;
		exp_taken = 1'b0;
		exp_mem = 1'b0;
		exp_load = 1'b0;
		exp_beats = 0;
		exp_data = '0;
		exp_target = '0;
		exp_addr = '0;
		exp_strb = '0;
		exp_size = '0;
		exp_wdata = '0;
	endtask

	// hand one instruction to the stage and wait for its completion
	task automatic issue(input exu_req_t r);
		r.rd = 5'($random(seed));
		r.wen = 1'($random(seed));
		exp_rd = r.rd;
		exp_wen = r.wen;
		in_req = r;
		in_valid = 1'b1;
		@(posedge clock);
		#1;
		in_valid = 1'b0;
		do @(negedge clock); while (!out_valid);
		@(posedge clock);
		#1;
	endtask

	task automatic run_alu_tests();
		logic [31:0] a;
		logic [31:0] b;
		for (int i = 0; i < 4; i++) begin
			for (int op = 0; op <= int'(ALU_EQ); op++) begin
				a = $random(seed);
				b = (i == 0) ? a : $random(seed);
				clear_expect();
				chk_data = 1'b1;
				exp_data = alu_expect(alu_op_e'(op), a, b);
				issue(make_req(alu_op_e'(op), MEM_NONE, CTRL_PLAIN, a, b, 0, 0, 0));
			end
		end
	endtask

	task automatic run_branch_tests();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] tgt;
		logic [31:0] pc;
		for (int i = 0; i < 2; i++) begin
			for (int k = int'(CTRL_BRANCH_EQ); k <= int'(CTRL_JALR); k++) begin
				a = $random(seed);
				b = (i == 0) ? a : $random(seed);
				tgt = $random(seed);
				pc = $random(seed);
				clear_expect();
				exp_target = tgt;
				case (ctrl_kind_e'(k))
					CTRL_BRANCH_EQ: exp_taken = (a == b);
					CTRL_BRANCH_NE: exp_taken = (a != b);
					CTRL_BRANCH_LT: exp_taken = ($signed(a) < $signed(b));
					CTRL_BRANCH_GE: exp_taken = ($signed(a) >= $signed(b));
					CTRL_JAL: exp_taken = 1'b1;
					default: begin
						exp_taken = 1'b1;
						exp_target = (a + b) & ~32'd1;
					end
				endcase
				if (k >= int'(CTRL_JAL)) begin
					chk_data = 1'b1;
					exp_data = pc + 32'd4;
				end
				issue(make_req((k == int'(CTRL_BRANCH_EQ) || k == int'(CTRL_BRANCH_NE)) ? ALU_EQ :
					(k >= int'(CTRL_JAL)) ? ALU_ADD : ALU_SLT, MEM_NONE, ctrl_kind_e'(k),
					a, b, 0, tgt, pc));
			end
		end
	endtask

	task automatic do_load(input mem_op_e op, input logic [7:0] addr);
		logic [2:0] off;
		off = addr[2:0];
		clear_expect();
		chk_data = 1'b1;
		exp_mem = 1'b1;
		exp_load = 1'b1;
		exp_addr = {24'd0, addr};
		exp_size = (op == MEM_LB || op == MEM_LBU) ? 3'd0 : (op == MEM_LW) ? 3'd2 : 3'd1;
		exp_data = load_expect(op, addr);
		// words at 5..7 and halves at 7 spill into the next beat
		exp_beats = ((op == MEM_LW && off >= 3'd5) ||
			((op == MEM_LH || op == MEM_LHU) && off == 3'd7)) ? 2 : 1;
		issue(make_req(ALU_ADD, op, CTRL_PLAIN, {24'd0, addr[7:3], 3'b000}, {29'd0, off}, 0, 0, 0));
	endtask

	task automatic do_store(input mem_op_e op, input logic [7:0] addr, input int nb);
		logic [31:0] sd;
		logic [63:0] lanes;
		sd = $random(seed);
		lanes = {sd, sd};
		clear_expect();
		exp_mem = 1'b1;
		exp_addr = {24'd0, addr};
		exp_size = (nb == 1) ? 3'd0 : (nb == 2) ? 3'd1 : 3'd2;
		exp_wdata = sd;
		exp_strb = 8'((8'((1 << nb) - 1)) << addr[2:0]);
		issue(make_req(ALU_ADD, op, CTRL_PLAIN, {24'd0, addr}, 0, sd, 0, 0));
		// shadow copy follows the strobed lanes
		for (int k = 0; k < 8; k++) begin
			if (exp_strb[k]) ref_mem[{addr[7:3], 3'(k)}] = lanes[8*k +: 8];
		end
	endtask

	// reset arrives while a load waits on the read address channel
	task automatic reset_during_load();
		clear_expect();
		exp_mem = 1'b1;
		exp_load = 1'b1;
		exp_addr = 32'h40;
		exp_size = 3'd2;
		in_req = make_req(ALU_ADD, MEM_LW, CTRL_PLAIN, 32'h40, 0, 0, 0, 0);
		in_valid = 1'b1;
		@(posedge clock);
		#1;
		in_valid = 1'b0;
		do begin
			@(posedge clock);
			#1;
		end while (!ar_valid);
		reset = 1'b1;
		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;
		@(posedge clock);
		#1;
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		mem_op_e load_ops [5];
		load_ops = '{MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
		for (int i = 0; i < 256; i++) ref_mem[i] = 8'(i);
		reset = 1'b1;
		in_valid = 1'b0;
		in_req = '0;
		clear_expect();
		exp_rd = '0;
		exp_wen = 1'b0;
		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;
		@(posedge clock);
		#1;
		run_alu_tests();
		run_branch_tests();
		// bytes here have bit 7 set, so sign and zero extension differ
		for (int i = 0; i < 5; i++) begin
			for (int off = 0; off < 8; off++) do_load(load_ops[i], 8'(8'hc0 + off));
		end
		for (int off = 0; off < 8; off++) begin
			do_store(MEM_SB, 8'(8'h80 + off), 1);
			do_load(MEM_LBU, 8'(8'h80 + off));
			do_store(MEM_SH, 8'(8'h90 + off), 2);
			do_load(MEM_LHU, 8'(8'h90 + off));
			do_store(MEM_SW, 8'(8'ha0 + off), 4);
			do_load(MEM_LW, 8'(8'ha0 + off));
		end
		reset_during_load();
		repeat (3) @(posedge clock);
		$display("errors: %0d checks, %0d protocol", errors, i_mem_model.protocol_errors);
		if (errors == 0 && i_mem_model.protocol_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
exu_pkg.sv
exu_alu.sv
exu_control.sv
exu_load_unit.sv
exu_store_unit.sv
exu_top.sv
tb_mem_model.sv
tb_exu.sv

// ==== run.sh ====
#!/bin/bash
# lint, build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --lint-only --timing --assert -Wno-fatal -f sources.f --top-module tb_exu
if [ $? -ne 0 ]; then
	echo "lint failed"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_exu -o sim_exu
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_exu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
	exit 0
fi
exit 1
